// ==== fft_params.svh ====
// ****************************************
// sizes and widths for the first SDF FFT
// stage, include wherever a width is needed
// ****************************************
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

`define FFT_N     32   // points per frame
`define FFT_HALF  16   // half frame, also feedback depth

`define IN_W      8    // input component
`define FB_W      9    // feedback component, one growth bit
`define TW_W      8    // twiddle component
`define OUT_W     14   // output component

// twiddles are Q1.6, so 64 stands for 1.0
`define TW_SHIFT  6

`endif

// ==== fft_pkg.sv ====
// ****************************************
// shared types of the SDF FFT stage, the
// complex sample structs and stage state
// ****************************************
`default_nettype none
`include "fft_params.svh"

package fft_pkg;

    typedef logic signed [`IN_W-1:0]  sample_t;
    typedef logic signed [`FB_W-1:0]  fb_t;
    typedef logic signed [`TW_W-1:0]  tw_t;
    typedef logic signed [`OUT_W-1:0] res_t;
    typedef logic [$clog2(`FFT_N)-1:0] idx_t;   // position inside a frame

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_in_t;

    typedef struct packed {
        fb_t re;
        fb_t im;
    } cplx_fb_t;

    typedef struct packed {
        tw_t re;
        tw_t im;
    } cplx_tw_t;

    typedef struct packed {
        res_t re;
        res_t im;
    } cplx_out_t;

    typedef enum logic {
        ST_FILL = 1'b0,   // first half, load line and emit twiddled diffs
        ST_BFLY = 1'b1    // second half, butterfly against the line
    } stage_state_e;

endpackage

`default_nettype wire

// ==== sdf_ctrl.sv ====
// ****************************************
// frame counter and twiddle ROM of the SDF
// stage, one count per valid sample
// ****************************************
`default_nettype none
`include "fft_params.svh"

module sdf_ctrl (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   valid_i,
    output fft_pkg::stage_state_e state_o,
    output fft_pkg::cplx_tw_t     twiddle_o,
    output logic                  shift_o,
    output logic                  valid_o
);
    import fft_pkg::*;

    localparam int IDX_W = $clog2(`FFT_N);
    localparam int K_W   = $clog2(`FFT_HALF);

    idx_t           cnt;
    logic           primed;     // one full frame seen since reset
    logic [K_W-1:0] k;          // twiddle index within the fill half

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            primed <= 1'b0;
        end else if (valid_i) begin
            cnt <= cnt + 1'b1;  // wraps at frame end
            if (cnt == idx_t'(`FFT_N - 1)) begin
                primed <= 1'b1;
            end
        end
    end

    assign state_o = cnt[IDX_W-1] ? ST_BFLY : ST_FILL;
    assign k       = cnt[K_W-1:0];

    // the line moves on every accepted sample, idle cycles freeze it
    assign shift_o = valid_i;
    assign valid_o = valid_i & ((state_o == ST_BFLY) | primed);

    // W32^k = cos(2*pi*k/32) - j*sin(2*pi*k/32), Q1.6
    always_comb begin
        case (k)
            4'd0:    twiddle_o = '{re: tw_t'(64),  im: tw_t'(0)};
            4'd1:    twiddle_o = '{re: tw_t'(63),  im: tw_t'(-12)};
            4'd2:    twiddle_o = '{re: tw_t'(59),  im: tw_t'(-24)};
            4'd3:    twiddle_o = '{re: tw_t'(53),  im: tw_t'(-36)};
            4'd4:    twiddle_o = '{re: tw_t'(45),  im: tw_t'(-45)};
            4'd5:    twiddle_o = '{re: tw_t'(36),  im: tw_t'(-53)};
            4'd6:    twiddle_o = '{re: tw_t'(24),  im: tw_t'(-59)};
            4'd7:    twiddle_o = '{re: tw_t'(12),  im: tw_t'(-63)};
            4'd8:    twiddle_o = '{re: tw_t'(0),   im: tw_t'(-64)};
            4'd9:    twiddle_o = '{re: tw_t'(-12), im: tw_t'(-63)};
            4'd10:   twiddle_o = '{re: tw_t'(-24), im: tw_t'(-59)};
            4'd11:   twiddle_o = '{re: tw_t'(-36), im: tw_t'(-53)};
            4'd12:   twiddle_o = '{re: tw_t'(-45), im: tw_t'(-45)};
            4'd13:   twiddle_o = '{re: tw_t'(-53), im: tw_t'(-36)};
            4'd14:   twiddle_o = '{re: tw_t'(-59), im: tw_t'(-24)};
            4'd15:   twiddle_o = '{re: tw_t'(-63), im: tw_t'(-12)};
            default: twiddle_o = '{re: tw_t'(64),  im: tw_t'(0)};
        endcase
    end

    // an output strobe needs a sample behind it
    a_valid_needs_input: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |-> valid_i
    ) else $error("valid_o without a registered sample");

endmodule

`default_nettype wire

// ==== sdf_delay_line.sv ====
// ****************************************
// feedback delay of the SDF stage, shifts
// once per valid sample, oldest at output
// ****************************************
`default_nettype none
`include "fft_params.svh"

module sdf_delay_line (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     shift_i,
    input  wire fft_pkg::cplx_fb_t  data_i,
    output fft_pkg::cplx_fb_t       data_o
);
    import fft_pkg::*;

    cplx_fb_t taps [`FFT_HALF];    // taps[0] newest

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FFT_HALF; i++) begin
                taps[i] <= '0;
            end
        end else if (shift_i) begin
            taps[0] <= data_i;
            for (int i = 1; i < `FFT_HALF; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign data_o = taps[`FFT_HALF-1];

    // an X written by the butterfly would circle round the loop
    a_fb_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(data_o)
    ) else $error("unknown value leaving the delay line");

endmodule

`default_nettype wire

// ==== sdf_butterfly.sv ====
// ****************************************
// radix-2 DIF butterfly, combinational,
// twiddle applied on the feedback path
// ****************************************
`default_nettype none
`include "fft_params.svh"

module sdf_butterfly (
    input  wire fft_pkg::stage_state_e state_i,
    input  wire fft_pkg::cplx_in_t     sample_i,
    input  wire fft_pkg::cplx_fb_t     fb_i,
    input  wire fft_pkg::cplx_tw_t     twiddle_i,
    output fft_pkg::cplx_fb_t          fb_o,
    output fft_pkg::cplx_out_t         data_o
);
    import fft_pkg::*;

    localparam int MUL_W = `FB_W + `TW_W;  // full product width

    fb_t                     in_re;       // input widened to feedback width
    fb_t                     in_im;
    logic signed [MUL_W-1:0] prod_re;
    logic signed [MUL_W-1:0] prod_im;
    logic signed [MUL_W-1:0] shr_re;
    logic signed [MUL_W-1:0] shr_im;
    logic                    fit_re;
    logic                    fit_im;

    assign in_re = sample_i.re;             // sign extends
    assign in_im = sample_i.im;

    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    assign prod_re = fb_i.re * twiddle_i.re - fb_i.im * twiddle_i.im;
    assign prod_im = fb_i.re * twiddle_i.im + fb_i.im * twiddle_i.re;

    assign shr_re = prod_re >>> `TW_SHIFT;  // back from Q1.6
    assign shr_im = prod_im >>> `TW_SHIFT;

    // bits above the output sign must all copy it
    assign fit_re = (&shr_re[MUL_W-1:`OUT_W-1]) | ~(|shr_re[MUL_W-1:`OUT_W-1]);
    assign fit_im = (&shr_im[MUL_W-1:`OUT_W-1]) | ~(|shr_im[MUL_W-1:`OUT_W-1]);

    always_comb begin
        case (state_i)
            ST_BFLY: begin
                data_o.re = fb_i.re + in_re;   // x[n] + x[n+16]
                data_o.im = fb_i.im + in_im;
                fb_o.re   = fb_i.re - in_re;   // diff goes back round
                fb_o.im   = fb_i.im - in_im;
            end
            default: begin
                // fill half, old diffs out with twiddle, new input in
                data_o.re = res_t'(shr_re);
                data_o.im = res_t'(shr_im);
                fb_o.re   = in_re;
                fb_o.im   = in_im;
            end
        endcase
    end

    // diffs span 9 bits and |W| <= 1, so the scaled product stays small
    a_product_fits: assert final (
        state_i !== ST_FILL || (fit_re !== 1'b0 && fit_im !== 1'b0)
    ) else $error("twiddled product overflows the output width");

endmodule

`default_nettype wire

// ==== fft_stage1.sv ====
// ****************************************
// first stage of a 32-point SDF FFT, one
// complex sample per valid, latency 1
// ****************************************
`default_nettype none

module fft_stage1 (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     valid_i,
    input  wire fft_pkg::cplx_in_t  data_i,
    output logic                    valid_o,
    output fft_pkg::cplx_out_t      data_o
);
    import fft_pkg::*;

    cplx_in_t     sample_q;      // registered input sample
    logic         valid_q;
    stage_state_e state;
    cplx_tw_t     twiddle;
    logic         shift;
    cplx_fb_t     fb_to_line;    // butterfly into delay line
    cplx_fb_t     fb_from_line;  // oldest entry back to butterfly

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        sample_q <= data_i;      // only read while valid_q
    end

    sdf_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_q),
        .state_o   (state),
        .twiddle_o (twiddle),
        .shift_o   (shift),
        .valid_o   (valid_o)
    );

    sdf_delay_line u_line (
        .clk     (clk),
        .rst_n   (rst_n),
        .shift_i (shift),
        .data_i  (fb_to_line),
        .data_o  (fb_from_line)
    );

    sdf_butterfly u_bfly (
        .state_i   (state),
        .sample_i  (sample_q),
        .fb_i      (fb_from_line),
        .twiddle_i (twiddle),
        .fb_o      (fb_to_line),
        .data_o    (data_o)
    );

endmodule

`default_nettype wire

// ==== tb_fft_stage1.sv ====
// ****************************************
// testbench of the first SDF FFT stage,
// random and full-scale frames checked
// against a frame-level reference model
// ****************************************
`default_nettype none
`include "fft_params.svh"

module tb_fft_stage1;
    import fft_pkg::*;

    localparam int  DRAIN_LIMIT = 200;   // idle cycles allowed for pending outputs
    localparam real PI          = 3.14159265358979;

    logic      clk;
    logic      rst_n;
    logic      valid_i;
    cplx_in_t  data_i;
    logic      valid_o;
    cplx_out_t data_o;

    cplx_in_t  frame_x [`FFT_N];      // frame about to be driven
    int        diff_re [`FFT_HALF];   // differences left in the delay line
    int        diff_im [`FFT_HALF];
    cplx_out_t exp_q [$];             // expected data_o, in order
    logic      drv_expect_valid;      // valid_o expected for the sample now driven
    logic      exp_valid_q;           // same, lined up with the input register
    bit        primed_model;
    bit        timed_out;
    int        errors;
    int        checks;
    int        tests_run;
    int        tests_failed;

    fft_stage1 dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .data_i  (data_i),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid_q <= 1'b0;
        end else begin
            exp_valid_q <= drv_expect_valid;
        end
    end

    // Q1.6 twiddle part, rounded half away from zero
    function automatic int round_q6(input real r);
        real s;
        s = r * 64.0;
        if (s >= 0.0) begin
            return $rtoi(s + 0.5);
        end else begin
            return -$rtoi(0.5 - s);
        end
    endfunction

    // expected outputs of one frame, given the diffs of the frame before
    function automatic void build_expected(input cplx_in_t x [`FFT_N], input bit primed);
        int        w_re;
        int        w_im;
        int        p_re;
        int        p_im;
        real       ang;
        cplx_out_t y;
        if (primed) begin
            for (int k = 0; k < `FFT_HALF; k++) begin
                ang  = 2.0 * PI * real'(k) / real'(`FFT_N);
                w_re = round_q6($cos(ang));
                w_im = round_q6(-$sin(ang));
                p_re = diff_re[k] * w_re - diff_im[k] * w_im;
                p_im = diff_re[k] * w_im + diff_im[k] * w_re;
                y.re = res_t'(p_re >>> `TW_SHIFT);
                y.im = res_t'(p_im >>> `TW_SHIFT);
                exp_q.push_back(y);
            end
        end
        for (int n = 0; n < `FFT_HALF; n++) begin
            y.re = res_t'(int'(x[n].re) + int'(x[n+`FFT_HALF].re));
            y.im = res_t'(int'(x[n].im) + int'(x[n+`FFT_HALF].im));
            exp_q.push_back(y);
            diff_re[n] = int'(x[n].re) - int'(x[n+`FFT_HALF].re);
            diff_im[n] = int'(x[n].im) - int'(x[n+`FFT_HALF].im);
        end
    endfunction

    task automatic check_sample(input cplx_out_t got, input cplx_out_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: data_o got (%0d, %0d) expected (%0d, %0d)",
                     $time, got.re, got.im, want.re, want.im);
        end
    endtask

    task automatic check_flag(input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: valid_o got %b expected %b", $time, got, want);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag(valid_o, exp_valid_q);
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: valid_o high while no output was expected", $time);
                end else begin
                    check_sample(data_o, exp_q.pop_front());
                end
            end
        end
    end

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        valid_i          = 1'b0;
        data_i           = '{re: sample_t'($urandom), im: sample_t'($urandom)};  // ignored
        drv_expect_valid = 1'b0;
    endtask

    task automatic drive_samples(input int lo, input int hi, input int gap_pct);
        int gaps;
        for (int n = lo; n < hi; n++) begin
            gaps = (int'($urandom % 100) < gap_pct) ? 1 + int'($urandom % 3) : 0;
            repeat (gaps) idle_cycle();
            @(posedge clk);
            #1;
            valid_i          = 1'b1;
            data_i           = frame_x[n];
            drv_expect_valid = primed_model || (n >= `FFT_HALF);
        end
    endtask

    task automatic run_frame(input int gap_pct);
        build_expected(frame_x, primed_model);
        drive_samples(0, `FFT_N, gap_pct);
        primed_model = 1'b1;
    endtask

    // idle until only `left` expected outputs remain
    task automatic settle(input int left);
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_q.size() > left && waited < DRAIN_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (exp_q.size() > left) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout at %0t: %0d expected outputs never appeared on data_o",
                     $time, exp_q.size() - left);
        end
        idle_cycle();
    endtask

    task automatic apply_reset();
        rst_n            = 1'b0;
        valid_i          = 1'b0;
        drv_expect_valid = 1'b0;
        primed_model     = 1'b0;
        exp_q.delete();
        for (int k = 0; k < `FFT_HALF; k++) begin
            diff_re[k] = 0;
            diff_im[k] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    function automatic void load_random();
        for (int n = 0; n < `FFT_N; n++) begin
            frame_x[n].re = sample_t'($urandom);
            frame_x[n].im = sample_t'($urandom);
        end
    endfunction

    function automatic void load_const(input int first, input int second);
        for (int n = 0; n < `FFT_N; n++) begin
            frame_x[n].re = sample_t'((n < `FFT_HALF) ? first : second);
            frame_x[n].im = sample_t'((n < `FFT_HALF) ? first : second);
        end
    endfunction

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        int err_before;
        rst_n            = 1'b0;
        valid_i          = 1'b0;
        data_i           = '0;
        drv_expect_valid = 1'b0;
        timed_out        = 1'b0;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        void'($urandom(59481));
        apply_reset();

        err_before = errors;
        load_random();
        build_expected(frame_x, primed_model);
        drive_samples(0, `FFT_HALF, 0);
        settle(`FFT_HALF);                 // sums of this frame still pending
        report_test("quiet after reset", err_before);

        err_before = errors;
        drive_samples(`FFT_HALF, `FFT_N, 0);
        primed_model = 1'b1;
        settle(0);
        report_test("first frame sums", err_before);

        if (!timed_out) begin
            err_before = errors;
            load_random();
            run_frame(0);
            settle(0);
            report_test("twiddled differences", err_before);
        end

        if (!timed_out) begin
            err_before = errors;
            load_random();
            run_frame(40);
            load_random();
            run_frame(40);
            settle(0);
            report_test("idle gaps", err_before);
        end

        // extreme inputs, diffs reach +255 and -255
        if (!timed_out) begin
            err_before = errors;
            load_const(127, 127);
            run_frame(0);
            load_const(127, -128);
            run_frame(0);
            load_const(-128, 127);
            run_frame(0);
            load_const(-128, -128);
            run_frame(0);
            settle(0);
            report_test("full scale", err_before);
        end

        if (!timed_out) begin
            err_before = errors;
            load_random();
            build_expected(frame_x, primed_model);
            drive_samples(0, 10, 0);
            settle(`FFT_N - 10);
            apply_reset();
            load_random();
            run_frame(0);
            load_random();
            run_frame(0);
            settle(0);
            report_test("mid-frame reset", err_before);
        end

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
fft_pkg.sv
sdf_ctrl.sv
sdf_delay_line.sv
sdf_butterfly.sv
fft_stage1.sv
tb_fft_stage1.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := tb_fft_stage1
FILELIST := sim.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) fft_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)
